//--- Makefile
VERILATOR ?= verilator
TOP ?= dot_engine_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only when the simulation output holds the pass line.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- adder_tree/add_pairs.sv
`timescale 1ns/1ns

module add_pairs #(
    parameter int DATA_W = 16,
    parameter int STAGE_N = 8
) (
    input  logic clk,
    input  logic [DATA_W*STAGE_N-1:0] din,
    output logic [(STAGE_N/2 + STAGE_N%2)*(DATA_W+1)-1:0] dout
);

    localparam int PAIRS = STAGE_N / 2;
    localparam int OUT_N = PAIRS + STAGE_N % 2;

    logic [DATA_W:0] lane_q [OUT_N];

    // lane 2i pairs with lane 2i+1, each operand extended by its own sign bit.
    for (genvar i = 0; i < PAIRS; i++) begin : g_pair
        logic [DATA_W-1:0] lo;
        logic [DATA_W-1:0] hi;

        assign lo = din[2*i*DATA_W +: DATA_W];
        assign hi = din[(2*i+1)*DATA_W +: DATA_W];

        always_ff @(posedge clk) begin
            lane_q[i] <= {lo[DATA_W-1], lo} + {hi[DATA_W-1], hi};
        end
    end

    // an unpaired top lane still takes one stage so all outputs stay aligned.
    if (STAGE_N % 2 == 1) begin : g_odd
        logic [DATA_W-1:0] rest;

        assign rest = din[(STAGE_N-1)*DATA_W +: DATA_W];

        always_ff @(posedge clk) begin
            lane_q[OUT_N-1] <= {rest[DATA_W-1], rest};
        end
    end

    always_comb begin
        for (int i = 0; i < OUT_N; i++) begin
            dout[i*(DATA_W+1) +: DATA_W+1] = lane_q[i];
        end
    end

endmodule

//--- adder_tree/adder_tree.sv
`timescale 1ns/1ns

module adder_tree #(
    parameter int DATA_W = 16,
    parameter int N = 8,
    parameter bit WRAP_IF = 1'b0
) (
    input  logic clk,
    input  logic reset,
    input  logic [DATA_W*N-1:0] din,
    input  logic in_valid,
    input  logic in_first,
    input  logic in_last,
    output logic [DATA_W+$clog2(N)-1:0] dout,
    output logic out_valid,
    output logic out_first,
    output logic out_last,
    prod_if.sink prod,
    sum_if.source sum
);

    localparam int DEPTH = $clog2(N);
    localparam int NEXT_N = N / 2 + N % 2;

    logic [DATA_W*N-1:0] din_sel;
    logic valid_sel;
    logic first_sel;
    logic last_sel;
    logic [NEXT_N*(DATA_W+1)-1:0] stage_out;
    logic valid_q;
    logic first_q;
    logic last_q;

    // the outermost level talks to the streams, the inner levels use plain ports.
    if (WRAP_IF) begin : g_wrap
        assign din_sel = prod.products;
        assign valid_sel = prod.valid;
        assign first_sel = prod.first;
        assign last_sel = prod.last;
        assign sum.sum = dout;
        assign sum.valid = out_valid;
        assign sum.first = out_first;
        assign sum.last = out_last;
    end else begin : g_plain
        assign din_sel = din;
        assign valid_sel = in_valid;
        assign first_sel = in_first;
        assign last_sel = in_last;
    end

    add_pairs #(
        .DATA_W(DATA_W),
        .STAGE_N(N)
    ) add_pairs_inst (
        .clk(clk),
        .din(din_sel),
        .dout(stage_out)
    );

    // one tag stage per level, so the tags see the same depth as the data.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_sel;
        end
    end

    always_ff @(posedge clk) begin
        first_q <= first_sel;
        last_q <= last_sel;
    end

    if (N == 2) begin : g_last
        assign dout = stage_out;
        assign out_valid = valid_q;
        assign out_first = first_q;
        assign out_last = last_q;
    end else begin : g_next
        adder_tree #(
            .DATA_W(DATA_W + 1),
            .N(NEXT_N),
            .WRAP_IF(1'b0)
        ) adder_tree_inst (
            .clk(clk),
            .reset(reset),
            .din(stage_out),
            .in_valid(valid_q),
            .in_first(first_q),
            .in_last(last_q),
            .dout(dout),
            .out_valid(out_valid),
            .out_first(out_first),
            .out_last(out_last),
            .prod(prod),
            .sum(sum)
        );
    end

    // the valid chain runs through every nested level below this one.
    a_tree_latency: assert property (
        @(posedge clk) disable iff (reset) out_valid |-> $past(valid_sel, DEPTH)
    );

endmodule

//--- common/dsp_ctrl_pkg.sv
package dsp_ctrl_pkg;

    // number of vectors that make up one frame.
    localparam int FRAME_LEN = 4;

    localparam int VEC_CNT_W = $clog2(FRAME_LEN);
    localparam int FRAME_CNT_W = 16;

    typedef logic [VEC_CNT_W-1:0] vec_cnt_t;
    typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;

    // counter value of the vector that closes a frame.
    localparam vec_cnt_t LAST_VEC = vec_cnt_t'(FRAME_LEN - 1);

    // idle means no vector of the current frame has been taken yet.
    typedef enum logic [0:0] {
        idle,
        in_frame
    } ctrl_state_t;

endpackage

//--- common/dsp_streams.sv
`timescale 1ns/1ns

// lane products from the multiplier into the adder tree.
interface prod_if;
    dsp_types_pkg::prod_vec_t products;
    logic valid;
    logic first;
    logic last;

    modport source (output products, valid, first, last);
    modport sink (input products, valid, first, last);
endinterface

// reduced vector sums from the adder tree into the accumulator.
interface sum_if;
    dsp_types_pkg::sum_t sum;
    logic valid;
    logic first;
    logic last;

    modport source (output sum, valid, first, last);
    modport sink (input sum, valid, first, last);
endinterface

//--- common/dsp_types_pkg.sv
package dsp_types_pkg;

    // lane count and per-lane widths of the datapath.
    localparam int LANES = 8;
    localparam int SAMPLE_W = 8;
    localparam int PROD_W = 2 * SAMPLE_W;

    // each tree stage adds one bit, so the tree sum grows by the stage count.
    localparam int TREE_DEPTH = $clog2(LANES);
    localparam int SUM_W = PROD_W + TREE_DEPTH;

    // the accumulator holds a whole frame of tree sums without overflow.
    localparam int ACC_W = SUM_W + $clog2(dsp_ctrl_pkg::FRAME_LEN);

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [PROD_W-1:0] prod_t;

    // lane 0 sits in the least significant slice.
    typedef logic [LANES*SAMPLE_W-1:0] sample_vec_t;
    typedef logic [LANES*PROD_W-1:0] prod_vec_t;

    typedef logic signed [SUM_W-1:0] sum_t;
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

//--- hw/dot_control.sv
`timescale 1ns/1ns

module dot_control (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic tag_valid,
    output logic tag_first,
    output logic tag_last,
    input  logic result_valid,
    output dsp_ctrl_pkg::frame_cnt_t frame_count
);

    dsp_ctrl_pkg::ctrl_state_t state;
    dsp_ctrl_pkg::ctrl_state_t state_next;
    dsp_ctrl_pkg::vec_cnt_t vec_cnt;

    // tags are taken from the count of vectors already seen in this frame.
    assign tag_valid = in_valid;
    assign tag_first = (vec_cnt == '0);
    assign tag_last = (vec_cnt == dsp_ctrl_pkg::LAST_VEC);

    always_comb begin
        state_next = state;
        case (state)
            dsp_ctrl_pkg::idle: begin
                if (in_valid && !tag_last) begin
                    state_next = dsp_ctrl_pkg::in_frame;
                end
            end
            dsp_ctrl_pkg::in_frame: begin
                if (in_valid && tag_last) begin
                    state_next = dsp_ctrl_pkg::idle;
                end
            end
            default: state_next = dsp_ctrl_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dsp_ctrl_pkg::idle;
            vec_cnt <= '0;
        end else begin
            state <= state_next;
            if (in_valid) begin
                vec_cnt <= tag_last ? '0 : vec_cnt + 1'b1;
            end
        end
    end

    // frames are counted when their result leaves the accumulator.
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_count <= '0;
        end else if (result_valid) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    a_idle_count_zero: assert property (
        @(posedge clk) disable iff (reset) (state == dsp_ctrl_pkg::idle) |-> (vec_cnt == '0)
    );

endmodule

//--- hw/dot_engine_top.sv
`timescale 1ns/1ns

module dot_engine_top (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  dsp_types_pkg::sample_vec_t in_a,
    input  dsp_types_pkg::sample_vec_t in_b,
    output dsp_types_pkg::acc_t result,
    output logic result_valid,
    output dsp_ctrl_pkg::frame_cnt_t frame_count
);

    logic tag_valid;
    logic tag_first;
    logic tag_last;

    prod_if prod_bus ();
    sum_if sum_bus ();

    dot_control dot_control_inst (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .tag_valid(tag_valid),
        .tag_first(tag_first),
        .tag_last(tag_last),
        .result_valid(result_valid),
        .frame_count(frame_count)
    );

    lane_multiplier lane_multiplier_inst (
        .clk(clk),
        .reset(reset),
        .in_a(in_a),
        .in_b(in_b),
        .tag_valid(tag_valid),
        .tag_first(tag_first),
        .tag_last(tag_last),
        .prod(prod_bus.source)
    );

    // the tree reads and writes the streams here, so its plain ports stay idle.
    adder_tree #(
        .DATA_W(dsp_types_pkg::PROD_W),
        .N(dsp_types_pkg::LANES),
        .WRAP_IF(1'b1)
    ) adder_tree_inst (
        .clk(clk),
        .reset(reset),
        .din('0),
        .in_valid(1'b0),
        .in_first(1'b0),
        .in_last(1'b0),
        .dout(),
        .out_valid(),
        .out_first(),
        .out_last(),
        .prod(prod_bus.sink),
        .sum(sum_bus.source)
    );

    frame_accumulator frame_accumulator_inst (
        .clk(clk),
        .reset(reset),
        .sum(sum_bus.sink),
        .result(result),
        .result_valid(result_valid)
    );

endmodule

//--- hw/frame_accumulator.sv
`timescale 1ns/1ns

module frame_accumulator (
    input  logic clk,
    input  logic reset,
    sum_if.sink sum,
    output dsp_types_pkg::acc_t result,
    output logic result_valid
);

    dsp_types_pkg::acc_t total;
    dsp_types_pkg::acc_t total_next;
    logic frame_open;

    // a first sum starts a new total, any other sum adds to it.
    always_comb begin
        if (sum.first) begin
            total_next = dsp_types_pkg::acc_t'(sum.sum);
        end else begin
            total_next = total + dsp_types_pkg::acc_t'(sum.sum);
        end
    end

    always_ff @(posedge clk) begin
        if (sum.valid) begin
            total <= total_next;
        end
        if (sum.valid && sum.last) begin
            result <= total_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= sum.valid && sum.last;
        end
    end

    // high between the first and the last sum of a frame.
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_open <= 1'b0;
        end else if (sum.valid) begin
            frame_open <= !sum.last;
        end
    end

    // the first tag comes from the control counter four stages upstream.
    a_no_nested_first: assert property (
        @(posedge clk) disable iff (reset) (sum.valid && sum.first) |-> !frame_open
    );

endmodule

//--- hw/lane_multiplier.sv
`timescale 1ns/1ns

module lane_multiplier (
    input  logic clk,
    input  logic reset,
    input  dsp_types_pkg::sample_vec_t in_a,
    input  dsp_types_pkg::sample_vec_t in_b,
    input  logic tag_valid,
    input  logic tag_first,
    input  logic tag_last,
    prod_if.source prod
);

    // both operands are widened as signed values, so the product keeps its sign.
    function automatic dsp_types_pkg::prod_t mul_lane(
        input dsp_types_pkg::sample_t a,
        input dsp_types_pkg::sample_t b
    );
        return dsp_types_pkg::prod_t'(a) * dsp_types_pkg::prod_t'(b);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= tag_valid;
        end
    end

    // products and frame tags move together in a single register stage.
    always_ff @(posedge clk) begin
        for (int i = 0; i < dsp_types_pkg::LANES; i++) begin
            prod.products[i*dsp_types_pkg::PROD_W +: dsp_types_pkg::PROD_W] <= mul_lane(
                in_a[i*dsp_types_pkg::SAMPLE_W +: dsp_types_pkg::SAMPLE_W],
                in_b[i*dsp_types_pkg::SAMPLE_W +: dsp_types_pkg::SAMPLE_W]
            );
        end
        prod.first <= tag_first;
        prod.last <= tag_last;
    end

endmodule

//--- test/dot_engine_tb.sv
`timescale 1ns/1ns

module dot_engine_tb;

    localparam int ROWS = 36;
    localparam int TESTS = 5;
    localparam int LATENCY = 5;
    localparam int DRAIN_LIMIT = 40;
    localparam int EXTREME_RESULT = 524288;

    logic clk = 1'b0;
    logic reset;
    logic in_valid;
    dsp_types_pkg::sample_vec_t in_a;
    dsp_types_pkg::sample_vec_t in_b;
    dsp_types_pkg::acc_t result;
    logic result_valid;
    dsp_ctrl_pkg::frame_cnt_t frame_count;

    // one vector per row, followed by its count of idle cycles.
    dsp_types_pkg::sample_vec_t row_a [ROWS];
    dsp_types_pkg::sample_vec_t row_b [ROWS];
    int row_gap [ROWS];

    // each test covers whole frames of the table.
    string test_name [TESTS];
    int test_first_row [TESTS];
    int test_rows [TESTS];

    int exp_value_q [$];
    int exp_cycle_q [$];

    int cycle = 0;
    int seed;
    int errors = 0;
    int checks = 0;
    int results_seen = 0;
    logic count_due = 1'b0;
    logic timed_out = 1'b0;
    dsp_types_pkg::acc_t last_result = '0;

    dot_engine_top dot_engine_top_inst (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_a(in_a),
        .in_b(in_b),
        .result(result),
        .result_valid(result_valid),
        .frame_count(frame_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic int dot_of(
        input dsp_types_pkg::sample_vec_t a,
        input dsp_types_pkg::sample_vec_t b
    );
        int sum;
        sum = 0;
        for (int i = 0; i < dsp_types_pkg::LANES; i++) begin
            sum += int'($signed(a[i*dsp_types_pkg::SAMPLE_W +: dsp_types_pkg::SAMPLE_W]))
                * int'($signed(b[i*dsp_types_pkg::SAMPLE_W +: dsp_types_pkg::SAMPLE_W]));
        end
        return sum;
    endfunction

    task automatic fill_table();
        for (int r = 0; r < 4; r++) begin
            row_a[r] = {dsp_types_pkg::LANES{8'h80}};
            row_b[r] = {dsp_types_pkg::LANES{8'h80}};
            row_gap[r] = r % 2;
        end
        row_a[4] = 64'h7f80_01ff_40c0_10f0;
        row_b[4] = 64'h7f7f_8080_c03f_f00f;
        row_a[5] = 64'hff01_ff01_8081_7e02;
        row_b[5] = 64'h0101_ffff_7f80_fe81;
        row_a[6] = 64'h1234_edcb_5a5a_a5a5;
        row_b[6] = 64'hc3c3_3c3c_0f0f_f0f0;
        row_a[7] = 64'h8000_7f00_0080_007f;
        row_b[7] = 64'h7f7f_8080_8080_7f7f;
        row_gap[4] = 2;
        row_gap[5] = 0;
        row_gap[6] = 1;
        row_gap[7] = 0;
        // back-to-back rows from a lane pattern that mixes signs.
        for (int r = 8; r < 16; r++) begin
            for (int i = 0; i < dsp_types_pkg::LANES; i++) begin
                row_a[r][i*8 +: 8] = 8'(r * 37 + i * 19 - 100);
                row_b[r][i*8 +: 8] = 8'(i * 53 - r * 29);
            end
            row_gap[r] = 0;
        end
        for (int r = 16; r < ROWS; r++) begin
            row_a[r] = {$random(seed), $random(seed)};
            row_b[r] = {$random(seed), $random(seed)};
            row_gap[r] = int'($unsigned($random(seed)) % 4);
        end
        test_name = '{"reset_idle", "extreme_frame", "mixed_sign_frame",
                      "back_to_back", "random_gaps"};
        test_first_row = '{0, 0, 4, 8, 16};
        test_rows = '{0, 4, 4, 8, 20};
    endtask

    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            checks++;
            assert (result_valid == 1'b0 && frame_count == '0) else begin
                $display("ERR %0t: outputs active before any input", $time);
                errors++;
            end
        end
    endtask

    task automatic run_rows(input int first, input int count);
        int frame_sum;
        frame_sum = 0;
        for (int r = first; r < first + count; r++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_a = row_a[r];
            in_b = row_b[r];
            frame_sum += dot_of(row_a[r], row_b[r]);
            // the strobe shows before the fifth edge after the one taking this vector.
            if ((r + 1) % dsp_ctrl_pkg::FRAME_LEN == 0) begin
                exp_value_q.push_back(frame_sum);
                exp_cycle_q.push_back(cycle + LATENCY);
                frame_sum = 0;
            end
            for (int g = 0; g < row_gap[r]; g++) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_results(input string name);
        int waited;
        waited = 0;
        while (exp_value_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_value_q.size() != 0) begin
            $display("timeout: %s never saw %0d expected results", name, exp_value_q.size());
            timed_out = 1'b1;
        end else begin
            // the frame counter check lands one edge after the last strobe.
            @(negedge clk);
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin : monitor
        int exp_value;
        int exp_cycle;
        if (count_due) begin
            checks++;
            assert (int'(frame_count) == results_seen) else begin
                $display("ERR %0t: frame_count %0d, expected %0d", $time,
                    frame_count, results_seen);
                errors++;
            end
            count_due = 1'b0;
        end
        if (!reset && result_valid) begin
            assert (exp_value_q.size() != 0) else begin
                $display("result strobe at %0t while no frame was outstanding", $time);
                errors++;
            end
            if (exp_value_q.size() != 0) begin
                exp_value = exp_value_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                last_result = result;
                checks += 2;
                assert (int'(result) == exp_value) else begin
                    $display("ERR %0t: result %0d, expected %0d", $time, result, exp_value);
                    errors++;
                end
                assert (cycle == exp_cycle) else begin
                    $display("ERR %0t: result at cycle %0d, expected cycle %0d", $time,
                        cycle, exp_cycle);
                    errors++;
                end
            end
            results_seen++;
            count_due = 1'b1;
        end
    end

    initial begin
        int errors_before;
        int results_before;
        reset = 1'b1;
        in_valid = 1'b0;
        in_a = '0;
        in_b = '0;
        seed = 32'h444f6659;
        fill_table();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < TESTS; t++) begin
            if (!timed_out) begin
                errors_before = errors;
                results_before = results_seen;
                if (t == 0) begin
                    check_idle(10);
                end else begin
                    run_rows(test_first_row[t], test_rows[t]);
                    wait_results(test_name[t]);
                end
                // the extreme frame is also held to its known value.
                if (t == 1 && !timed_out) begin
                    checks++;
                    assert (int'(last_result) == EXTREME_RESULT) else begin
                        $display("ERR %0t: extreme frame result %0d, expected %0d", $time,
                            last_result, EXTREME_RESULT);
                        errors++;
                    end
                end
                $display("test %0d %s: %0d results, %0d errors", t + 1, test_name[t],
                    results_seen - results_before, errors - errors_before);
            end
        end
        $display("summary: %0d checks, %0d results, %0d errors", checks, results_seen, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/dsp_ctrl_pkg.sv
common/dsp_types_pkg.sv
common/dsp_streams.sv
adder_tree/add_pairs.sv
adder_tree/adder_tree.sv
hw/lane_multiplier.sv
hw/frame_accumulator.sv
hw/dot_control.sv
hw/dot_engine_top.sv
test/dot_engine_tb.sv
